// File: all.f
design/mipsPkg.sv
design/fetchUnit.sv
design/programMemory.sv
design/controlUnit.sv
design/registerFile.sv
design/alu.sv
design/dataBus.sv
design/mipsProcessor.sv
verif/mipsTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; exit status is the simulation result
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f all.f --top-module mipsTb -Mdir build/obj
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./build/obj/VmipsTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

// File: verif/mipsTb.sv
// Directed testbench for the MIPS core that loads a program per test and checks writebacks
`timescale 1ns/1ns

module mipsTb;

	localparam int MEMORY_DEPTH = 512;
	localparam int DATA_DEPTH = 256;
	// Cycles any single wait may take
	localparam int WAIT_LIMIT = 64;

	logic clk;
	logic rst;
	logic progWrite;
	logic [$clog2(MEMORY_DEPTH)-1:0] progAddr;
	logic [31:0] progData;
	logic [7:0] portIn;
	logic [31:0] portOut;
	mipsPkg::writeback wb;

	// Program image and expected write sequence for the running test
	logic [31:0] prog[$];
	mipsPkg::writeback expected[$];
	logic [31:0] lfsrState;

	mipsProcessor #(
		.MEMORY_DEPTH(MEMORY_DEPTH),
		.DATA_DEPTH(DATA_DEPTH)
	) mipsProcessor_inst (
		.clk(clk),
		.rst(rst),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.portIn(portIn),
		.portOut(portOut),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkWord(input string name, input logic [31:0] actual,
		input logic [31:0] want);
		if (actual !== want) begin
			failRun($sformatf("mismatch at %0t ns: %s = %h, expected %h", $time, name,
				actual, want));
		end
	endtask

	task automatic checkWriteback(input string name, input mipsPkg::writeback actual,
		input mipsPkg::writeback want);
		if (actual !== want) begin
			failRun($sformatf("mismatch at %0t ns: %s = v%0b r%0d %h, expected v%0b r%0d %h",
				$time, name, actual.valid, actual.regIdx, actual.data,
				want.valid, want.regIdx, want.data));
		end
	endtask

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < count; k++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Instruction encoders in MIPS field layout
	function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [31:0] dest);
		return {mipsPkg::OP_J, dest[27:2]};
	endfunction

	function automatic mipsPkg::writeback writeOf(input logic [4:0] idx,
		input logic [31:0] data);
		mipsPkg::writeback w;
		w.valid = 1'b1;
		w.regIdx = idx;
		w.data = data;
		return w;
	endfunction

	function automatic logic [31:0] signExt(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// Appends a self-jump as halt, loads under reset, then holds reset 16 cycles
	task automatic startProgram();
		prog.push_back(encodeJ(mipsPkg::TEXT_BASE + 32'(4 * prog.size())));
		@(posedge clk);
		rst <= 1'b1;
		foreach (prog[k]) begin
			progWrite <= 1'b1;
			progAddr <= 9'(k);
			progData <= prog[k];
			@(posedge clk);
		end
		progWrite <= 1'b0;
		repeat (15) @(posedge clk);
		// Reset state
		@(negedge clk);
		checkWord("wb.valid", 32'(wb.valid), 32'd0);
		checkWord("portOut", portOut, 32'd0);
		@(posedge clk);
		rst <= 1'b0;
	endtask

	// Sampled mid-cycle well clear of the drive edge
	task automatic expectWrites();
		int waited;
		foreach (expected[n]) begin
			waited = 0;
			@(negedge clk);
			while (!wb.valid) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					failRun($sformatf("timed out waiting for register write %0d at %0t ns",
						n, $time));
				end
				@(negedge clk);
			end
			checkWriteback("wb", wb, expected[n]);
		end
	endtask

	task automatic expectQuiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (wb.valid) begin
				failRun($sformatf("unexpected write to register %0d at %0t ns",
					wb.regIdx, $time));
			end
		end
	endtask

	task automatic testReset();
		prog.delete();
		startProgram();
		repeat (6) begin
			@(negedge clk);
			checkWord("wb.valid", 32'(wb.valid), 32'd0);
			checkWord("portOut", portOut, 32'd0);
		end
	endtask

	task automatic testArithmetic();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immNeg;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r10;
		logic [31:0] r11;
		immA = 16'(randomBits(16));
		immB = 16'(randomBits(16));
		// Top bit forced so both extensions are exercised
		immNeg = immA | 16'h8000;
		r1 = signExt(immA);
		r2 = {16'd0, immB};
		r10 = signExt(immNeg);
		r11 = {16'd0, immNeg};
		prog.delete();
		expected.delete();
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd1, immA));
		prog.push_back(encodeI(mipsPkg::OP_ORI, 5'd0, 5'd2, immB));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd10, immNeg));
		prog.push_back(encodeI(mipsPkg::OP_ORI, 5'd0, 5'd11, immNeg));
		prog.push_back(encodeR(mipsPkg::FN_ADD, 5'd1, 5'd2, 5'd4));
		prog.push_back(encodeR(mipsPkg::FN_SUB, 5'd1, 5'd2, 5'd5));
		prog.push_back(encodeR(mipsPkg::FN_AND, 5'd1, 5'd10, 5'd6));
		prog.push_back(encodeR(mipsPkg::FN_OR, 5'd2, 5'd10, 5'd7));
		prog.push_back(encodeR(mipsPkg::FN_NOR, 5'd1, 5'd2, 5'd8));
		// Destination $zero is never reported
		prog.push_back(encodeR(mipsPkg::FN_ADD, 5'd1, 5'd2, 5'd0));
		prog.push_back(encodeR(mipsPkg::FN_SUB, 5'd10, 5'd11, 5'd9));
		expected.push_back(writeOf(5'd1, r1));
		expected.push_back(writeOf(5'd2, r2));
		expected.push_back(writeOf(5'd10, r10));
		expected.push_back(writeOf(5'd11, r11));
		expected.push_back(writeOf(5'd4, r1 + r2));
		expected.push_back(writeOf(5'd5, r1 - r2));
		expected.push_back(writeOf(5'd6, r1 & r10));
		expected.push_back(writeOf(5'd7, r2 | r10));
		expected.push_back(writeOf(5'd8, ~(r1 | r2)));
		expected.push_back(writeOf(5'd9, r10 - r11));
		startProgram();
		expectWrites();
		expectQuiet(8);
	endtask

	task automatic testBranches();
		prog.delete();
		expected.delete();
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd1, 16'd5));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd2, 16'd5));
		// Taken beq skips the next word
		prog.push_back(encodeI(mipsPkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd3, 16'd99));
		// bne falls through
		prog.push_back(encodeI(mipsPkg::OP_BNE, 5'd1, 5'd2, 16'd1));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd4, 16'd7));
		// Taken bne over two words
		prog.push_back(encodeI(mipsPkg::OP_BNE, 5'd1, 5'd4, 16'd2));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd5, 16'd99));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd12, 16'd99));
		// beq falls through
		prog.push_back(encodeI(mipsPkg::OP_BEQ, 5'd1, 5'd4, 16'd1));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd6, 16'd8));
		expected.push_back(writeOf(5'd1, 32'd5));
		expected.push_back(writeOf(5'd2, 32'd5));
		expected.push_back(writeOf(5'd4, 32'd7));
		expected.push_back(writeOf(5'd6, 32'd8));
		startProgram();
		expectWrites();
		expectQuiet(8);
	endtask

	task automatic testJump();
		prog.delete();
		expected.delete();
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd1, 16'd1));
		// Unsupported sll only advances the PC
		prog.push_back(32'h0001_0840);
		prog.push_back(encodeJ(mipsPkg::TEXT_BASE + 32'd16));
		// Marked word that must be jumped over
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd2, 16'h0BAD));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd3, 16'd3));
		expected.push_back(writeOf(5'd1, 32'd1));
		expected.push_back(writeOf(5'd3, 32'd3));
		startProgram();
		expectWrites();
		expectQuiet(8);
	endtask

	task automatic testMemory();
		logic [15:0] valA;
		logic [15:0] valB;
		logic [31:0] base;
		valA = 16'(randomBits(16));
		valB = 16'(randomBits(16));
		prog.delete();
		expected.delete();
		// Without lui DATA_BASE comes from 0x2002 doubled 15 times
		base = 32'h2002;
		prog.push_back(encodeI(mipsPkg::OP_ORI, 5'd0, 5'd1, 16'h2002));
		expected.push_back(writeOf(5'd1, base));
		repeat (15) begin
			base = base + base;
			prog.push_back(encodeR(mipsPkg::FN_ADD, 5'd1, 5'd1, 5'd1));
			expected.push_back(writeOf(5'd1, base));
		end
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd2, valA));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd3, valB));
		prog.push_back(encodeI(mipsPkg::OP_SW, 5'd1, 5'd2, 16'd0));
		prog.push_back(encodeI(mipsPkg::OP_SW, 5'd1, 5'd3, 16'd12));
		// Read back in the other order
		prog.push_back(encodeI(mipsPkg::OP_LW, 5'd1, 5'd4, 16'd12));
		prog.push_back(encodeI(mipsPkg::OP_LW, 5'd1, 5'd5, 16'd0));
		expected.push_back(writeOf(5'd2, signExt(valA)));
		expected.push_back(writeOf(5'd3, signExt(valB)));
		expected.push_back(writeOf(5'd4, signExt(valB)));
		expected.push_back(writeOf(5'd5, signExt(valA)));
		startProgram();
		expectWrites();
		expectQuiet(8);
	endtask

	task automatic testPortIo();
		logic [7:0] inValue;
		logic [15:0] outValue;
		inValue = 8'(randomBits(8)) | 8'h80;
		outValue = 16'(randomBits(16));
		prog.delete();
		expected.delete();
		// PORT_ADDR is the complement of 0x0000FFFF
		prog.push_back(encodeI(mipsPkg::OP_ORI, 5'd0, 5'd1, 16'hFFFF));
		prog.push_back(encodeR(mipsPkg::FN_NOR, 5'd1, 5'd0, 5'd1));
		prog.push_back(encodeI(mipsPkg::OP_LW, 5'd1, 5'd2, 16'd0));
		prog.push_back(encodeI(mipsPkg::OP_ADDI, 5'd0, 5'd3, outValue));
		prog.push_back(encodeI(mipsPkg::OP_SW, 5'd1, 5'd3, 16'd0));
		expected.push_back(writeOf(5'd1, 32'h0000_FFFF));
		expected.push_back(writeOf(5'd1, mipsPkg::PORT_ADDR));
		expected.push_back(writeOf(5'd2, {24'd0, inValue}));
		expected.push_back(writeOf(5'd3, signExt(outValue)));
		@(posedge clk);
		portIn <= inValue;
		startProgram();
		expectWrites();
		// Port not yet updated while the store executes
		@(negedge clk);
		checkWord("portOut", portOut, 32'd0);
		@(negedge clk);
		checkWord("portOut", portOut, signExt(outValue));
		expectQuiet(4);
	endtask

	initial begin
		rst = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		portIn = '0;
		lfsrState = 32'hf3aa;
		testArithmetic();
		testPortIo();
		// Runs after the port store so the reset has to clear portOut
		testReset();
		testBranches();
		testJump();
		testMemory();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: design/mipsProcessor.sv
// Top level of the single-cycle MIPS core, the DUT seen by the testbench
`timescale 1ns/1ns

module mipsProcessor #(
	parameter int MEMORY_DEPTH = 512,
	parameter int DATA_DEPTH = 256
) (
	input logic clk,
	input logic rst,
	input logic progWrite,
	input logic [$clog2(MEMORY_DEPTH)-1:0] progAddr,
	input logic [31:0] progData,
	input logic [7:0] portIn,
	output logic [31:0] portOut,
	output mipsPkg::writeback wb
);

	logic [31:0] pc;
	mipsPkg::instrFields instr;
	mipsPkg::ctrlSignals ctrl;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic [4:0] writeIdx;
	logic [31:0] immExt;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic zero;
	logic [31:0] memData;
	logic [31:0] resultData;

	// Fetch
	fetchUnit fetchUnit_inst (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.ctrl(ctrl),
		.zero(zero),
		.pc(pc)
	);

	programMemory #(
		.MEMORY_DEPTH(MEMORY_DEPTH)
	) programMemory_inst (
		.clk(clk),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.pc(pc),
		.instr(instr)
	);

	// Decode
	controlUnit controlUnit_inst (
		.instr(instr),
		.ctrl(ctrl)
	);

	// rd for R-type, rt for immediates and loads
	assign writeIdx = ctrl.regDst ? instr.r.rd : instr.r.rt;

	registerFile registerFile_inst (
		.clk(clk),
		.rst(rst),
		.rs(instr.r.rs),
		.rt(instr.r.rt),
		.writeIdx(writeIdx),
		.writeEnable(ctrl.regWrite),
		.writeData(resultData),
		.readData1(readData1),
		.readData2(readData2),
		.wb(wb)
	);

	// ori zero-extends, everything else sign-extends
	assign immExt = ctrl.zeroExtImm ? {16'd0, instr.i.imm16}
		: {{16{instr.i.imm16[15]}}, instr.i.imm16};

	// Execute
	assign aluB = ctrl.aluSrc ? immExt : readData2;

	alu alu_inst (
		.op(ctrl.aluOp),
		.a(readData1),
		.b(aluB),
		.result(aluResult),
		.zero(zero)
	);

	// Memory and port access, address from the ALU
	dataBus #(
		.DATA_DEPTH(DATA_DEPTH)
	) dataBus_inst (
		.clk(clk),
		.rst(rst),
		.address(aluResult),
		.writeData(readData2),
		.memRead(ctrl.memRead),
		.memWrite(ctrl.memWrite),
		.portIn(portIn),
		.readData(memData),
		.portOut(portOut)
	);

	// Writeback value, loads take the bus data
	assign resultData = ctrl.memRead ? memData : aluResult;

endmodule

// File: design/dataBus.sv
// Data memory and memory-mapped I/O port decode, instantiated by mipsProcessor
`timescale 1ns/1ns

module dataBus #(
	parameter int DATA_DEPTH = 256
) (
	input logic clk,
	input logic rst,
	input logic [31:0] address,
	input logic [31:0] writeData,
	input logic memRead,
	input logic memWrite,
	input logic [7:0] portIn,
	output logic [31:0] readData,
	output logic [31:0] portOut
);

	logic [31:0] ram [DATA_DEPTH];
	logic [31:0] ramOffset;
	logic [$clog2(DATA_DEPTH)-1:0] ramIdx;
	logic isPort;
	logic inRange;

	// Address decode
	assign isPort = (address == mipsPkg::PORT_ADDR);
	assign ramOffset = (address - mipsPkg::DATA_BASE) >> 2;
	assign ramIdx = ramOffset[$clog2(DATA_DEPTH)-1:0];
	assign inRange = ramOffset < 32'(DATA_DEPTH);

	// Port reads come back zero-extended
	always_comb begin
		readData = '0;
		if (memRead) begin
			if (isPort) begin
				readData = {24'd0, portIn};
			end else if (inRange) begin
				readData = ram[ramIdx];
			end
		end
	end

	// RAM keeps its contents across reset
	always_ff @(posedge clk) begin
		if (memWrite && !isPort && inRange) begin
			ram[ramIdx] <= writeData;
		end
	end

	// Output port register
	always_ff @(posedge clk) begin
		if (rst) begin
			portOut <= '0;
		end else if (memWrite && isPort) begin
			portOut <= writeData;
		end
	end

endmodule

// File: design/alu.sv
// Five-operation ALU with zero flag, instantiated by mipsProcessor
`timescale 1ns/1ns

module alu (
	input mipsPkg::aluOp op,
	input logic [31:0] a,
	input logic [31:0] b,
	output logic [31:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			// Wraparound, no overflow trap
			mipsPkg::ALU_ADD: result = a + b;
			mipsPkg::ALU_SUB: result = a - b;
			mipsPkg::ALU_AND: result = a & b;
			mipsPkg::ALU_OR: result = a | b;
			mipsPkg::ALU_NOR: result = ~(a | b);
			default: result = '0;
		endcase
	end

	// Branch compare flag
	assign zero = (result == 32'd0);

endmodule

// File: design/registerFile.sv
// 32-entry register file with writeback report, instantiated by mipsProcessor
`timescale 1ns/1ns

module registerFile (
	input logic clk,
	input logic rst,
	input logic [4:0] rs,
	input logic [4:0] rt,
	input logic [4:0] writeIdx,
	input logic writeEnable,
	input logic [31:0] writeData,
	output logic [31:0] readData1,
	output logic [31:0] readData2,
	output mipsPkg::writeback wb
);

	logic [31:0] regs [32];
	logic doWrite;

	// $zero never takes a write, and nothing lands while in reset
	assign doWrite = writeEnable && (writeIdx != 5'd0) && !rst;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < 32; k++) begin
				regs[k] <= '0;
			end
		end else if (doWrite) begin
			regs[writeIdx] <= writeData;
		end
	end

	// Combinational read, register 0 stays zero
	assign readData1 = regs[rs];
	assign readData2 = regs[rt];

	// Reports the write that the coming edge performs
	assign wb.valid = doWrite;
	assign wb.regIdx = writeIdx;
	assign wb.data = writeData;

endmodule

// File: design/controlUnit.sv
// Main decoder with ALU control folded in, instantiated by mipsProcessor
`timescale 1ns/1ns

module controlUnit (
	input mipsPkg::instrFields instr,
	output mipsPkg::ctrlSignals ctrl
);

	always_comb begin
		// Inactive unless a supported encoding matches
		ctrl = '0;
		ctrl.aluOp = mipsPkg::ALU_ADD;
		case (instr.r.opcode)
			mipsPkg::OP_RTYPE: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.r.funct)
					mipsPkg::FN_ADD: ctrl.aluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB: ctrl.aluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: ctrl.aluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: ctrl.aluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_NOR: ctrl.aluOp = mipsPkg::ALU_NOR;
					default: begin
						// Unknown funct, including the all-zero word
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
					end
				endcase
			end
			mipsPkg::OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			mipsPkg::OP_ORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExtImm = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_OR;
			end
			mipsPkg::OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
			end
			mipsPkg::OP_SW: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::OP_BEQ: begin
				// Compare by subtraction, zero flag decides
				ctrl.branchEq = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_SUB;
			end
			mipsPkg::OP_BNE: begin
				ctrl.branchNe = 1'b1;
				ctrl.aluOp = mipsPkg::ALU_SUB;
			end
			mipsPkg::OP_J: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: design/programMemory.sv
// Instruction memory with a load port and asynchronous fetch, instantiated by mipsProcessor
`timescale 1ns/1ns

module programMemory #(
	parameter int MEMORY_DEPTH = 512
) (
	input logic clk,
	input logic progWrite,
	input logic [$clog2(MEMORY_DEPTH)-1:0] progAddr,
	input logic [31:0] progData,
	input logic [31:0] pc,
	output mipsPkg::instrFields instr
);

	logic [31:0] mem [MEMORY_DEPTH];
	logic [31:0] wordOffset;
	logic inRange;

	// Word index relative to the text segment
	assign wordOffset = (pc - mipsPkg::TEXT_BASE) >> 2;
	assign inRange = wordOffset < 32'(MEMORY_DEPTH);

	// Outside the loaded image reads as a no-op
	assign instr = inRange ? mem[wordOffset[$clog2(MEMORY_DEPTH)-1:0]] : '0;

	// Loader port, used while the core sits in reset
	always_ff @(posedge clk) begin
		if (progWrite) begin
			mem[progAddr] <= progData;
		end
	end

endmodule

// File: design/fetchUnit.sv
// Program counter and next-PC select for the core, instantiated once by mipsProcessor
`timescale 1ns/1ns

module fetchUnit (
	input logic clk,
	input logic rst,
	input mipsPkg::instrFields instr,
	input mipsPkg::ctrlSignals ctrl,
	input logic zero,
	output logic [31:0] pc
);

	logic [31:0] pcPlus4;
	logic [31:0] branchOffset;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic takeBranch;
	logic [31:0] nextPc;

	assign pcPlus4 = pc + 32'd4;

	// Sign-extended word offset
	assign branchOffset = {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign branchTarget = pcPlus4 + branchOffset;

	// Upper nibble kept from the delay-slot address
	assign jumpTarget = {pcPlus4[31:28], instr.j.target26, 2'b00};

	// beq wants equal operands, bne wants them different
	assign takeBranch = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

	always_comb begin
		if (ctrl.jump) begin
			nextPc = jumpTarget;
		end else if (takeBranch) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= mipsPkg::TEXT_BASE;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// File: design/mipsPkg.sv
// Shared types and constants for the single-cycle MIPS core, referenced by scoped name
package mipsPkg;

	// Reset PC and start of the text segment
	localparam logic [31:0] TEXT_BASE = 32'h0040_0000;
	// First byte address of data memory
	localparam logic [31:0] DATA_BASE = 32'h1001_0000;
	// Memory-mapped I/O port, load reads portIn and store writes portOut
	localparam logic [31:0] PORT_ADDR = 32'hFFFF_0000;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_ORI = 6'h0D;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2B;

	// R-type function codes
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_NOR = 6'h27;

	// Register format
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFormat;

	// Immediate format, shares opcode/rs/rt positions with rFormat
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iFormat;

	// Jump format
	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} jFormat;

	// One instruction word seen through all three formats
	typedef union packed {
		rFormat r;
		iFormat i;
		jFormat j;
	} instrFields;

	// ALU operations
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_NOR = 3'd4
	} aluOp;

	// Decoded control for one instruction
	typedef struct packed {
		logic regWrite;
		logic regDst;
		logic aluSrc;
		logic zeroExtImm;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic jump;
		aluOp aluOp;
	} ctrlSignals;

	// Register write report for the instruction in flight
	typedef struct packed {
		logic valid;
		logic [4:0] regIdx;
		logic [31:0] data;
	} writeback;

endpackage
